// File: rv_core_pkg.sv
package rv_core_pkg;

    localparam int unsigned xlen = 32;

    typedef logic [3:0] reg_addr_t;  // RV32E has 16 registers

    // Major opcodes
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    // funct3 values
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010;  // LW, SW
    localparam logic [2:0] f3_byte    = 3'b000;  // SB

    localparam logic [6:0] funct7_sub = 7'b0100000;  // Bit 30 turns ADD into SUB

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // One instruction word, three ways to read it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_u;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_u          instr;
    } fetch_to_ex_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic            illegal;
        logic            reg_we;
        reg_addr_t       rd;
        logic [xlen-1:0] alu_result;  // Also the load/store address
        logic [xlen-1:0] store_data;
        logic            mem_read;
        logic            mem_write;
        logic            byte_store;
    } ex_to_mem_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic            illegal;
        logic            reg_we;
        reg_addr_t       rd;
        logic [xlen-1:0] wdata;
    } retire_t;

endpackage

// File: instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch #(
    parameter int unsigned imem_depth = 256
) (
    input  logic                           cpu_clk,
    input  logic                           rst_n,
    input  logic                           step_en,
    input  logic                           debug_imem_we,
    input  logic [31:0]                    debug_addr,
    input  logic [31:0]                    debug_wdata,
    output rv_core_pkg::fetch_to_ex_t      fetch
);

    localparam int unsigned imem_aw = $clog2(imem_depth);

    logic [31:0]                   imem [imem_depth];
    logic [rv_core_pkg::xlen-1:0]  pc;
    logic [imem_aw-1:0]            fetch_idx;
    logic [imem_aw-1:0]            debug_idx;

    // Word-indexed so the two low address bits are dropped
    assign fetch_idx = pc[imem_aw+1:2];
    assign debug_idx = debug_addr[imem_aw+1:2];

    // Program loading happens only while the core is frozen
    always_ff @(posedge cpu_clk) begin
        if (!step_en && debug_imem_we) begin
            imem[debug_idx] <= debug_wdata;
        end
    end

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (step_en) begin
            pc <= pc + 32'd4;  // Straight-line only since there are no branches
        end
    end

    // Fetch register toward execute
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch <= '0;
        end else if (step_en) begin
            fetch.valid <= 1'b1;
            fetch.pc    <= pc;
            fetch.instr <= imem[fetch_idx];
        end
    end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                          cpu_clk,
    input  logic                          rst_n,
    input  logic                          step_en,
    input  rv_core_pkg::reg_addr_t        rs1,
    input  rv_core_pkg::reg_addr_t        rs2,
    output logic [rv_core_pkg::xlen-1:0]  rs1_data,
    output logic [rv_core_pkg::xlen-1:0]  rs2_data,
    input  logic                          wb_we,
    input  rv_core_pkg::reg_addr_t        wb_rd,
    input  logic [rv_core_pkg::xlen-1:0]  wb_data
);

    logic [rv_core_pkg::xlen-1:0] regs [16];

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (step_en && wb_we && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;  // x0 writes never land
        end
    end

    // x0 stays zero since it is never written after reset
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: decode_execute.sv
`timescale 1ns/1ps

module decode_execute (
    input  logic                          cpu_clk,
    input  logic                          rst_n,
    input  logic                          step_en,
    input  rv_core_pkg::fetch_to_ex_t     fetch,
    input  logic                          wb_we,
    input  rv_core_pkg::reg_addr_t        wb_rd,
    input  logic [rv_core_pkg::xlen-1:0]  wb_data,
    output rv_core_pkg::ex_to_mem_t       exec
);

    rv_core_pkg::instr_u           instr;
    rv_core_pkg::reg_addr_t        rs1_idx;
    rv_core_pkg::reg_addr_t        rs2_idx;
    logic [rv_core_pkg::xlen-1:0]  rs1_data;
    logic [rv_core_pkg::xlen-1:0]  rs2_data;
    logic [rv_core_pkg::xlen-1:0]  op_a;
    logic [rv_core_pkg::xlen-1:0]  op_b;
    logic [rv_core_pkg::xlen-1:0]  imm_i;
    logic [rv_core_pkg::xlen-1:0]  imm_s;
    logic                          fwd_a;
    logic                          fwd_b;
    rv_core_pkg::ex_to_mem_t       exec_next;

    assign instr   = fetch.instr;
    assign rs1_idx = instr.r_fmt.rs1[3:0];  // rs1/rs2 sit in the same bits in every form
    assign rs2_idx = instr.r_fmt.rs2[3:0];

    register_file register_file_i (
        .cpu_clk  (cpu_clk),
        .rst_n    (rst_n),
        .step_en  (step_en),
        .rs1      (rs1_idx),
        .rs2      (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    // Bypass from the memory stage that also covers load-use
    assign fwd_a = fetch.valid && wb_we && (wb_rd != '0) && (wb_rd == rs1_idx);
    assign fwd_b = fetch.valid && wb_we && (wb_rd != '0) && (wb_rd == rs2_idx);
    assign op_a  = fwd_a ? wb_data : rs1_data;
    assign op_b  = fwd_b ? wb_data : rs2_data;

    assign imm_i = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
    assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};

    always_comb begin
        exec_next            = '0;
        exec_next.valid      = fetch.valid;
        exec_next.pc         = fetch.pc;
        exec_next.store_data = op_b;
        case (instr.r_fmt.opcode)
            rv_core_pkg::op_reg: begin
                exec_next.reg_we  = 1'b1;
                exec_next.rd      = instr.r_fmt.rd[3:0];
                exec_next.illegal = instr.r_fmt.rd[4] | instr.r_fmt.rs1[4] | instr.r_fmt.rs2[4];
                if (instr.r_fmt.funct7 == rv_core_pkg::funct7_sub &&
                    instr.r_fmt.funct3 == rv_core_pkg::f3_add_sub) begin
                    exec_next.alu_result = op_a - op_b;
                end else if (instr.r_fmt.funct7 != 7'b0) begin
                    exec_next.illegal = 1'b1;
                end else begin
                    case (instr.r_fmt.funct3)
                        rv_core_pkg::f3_add_sub: exec_next.alu_result = op_a + op_b;
                        rv_core_pkg::f3_xor:     exec_next.alu_result = op_a ^ op_b;
                        rv_core_pkg::f3_or:      exec_next.alu_result = op_a | op_b;
                        rv_core_pkg::f3_and:     exec_next.alu_result = op_a & op_b;
                        default:                 exec_next.illegal    = 1'b1;
                    endcase
                end
            end
            rv_core_pkg::op_imm, rv_core_pkg::op_load: begin
                exec_next.reg_we     = 1'b1;
                exec_next.rd         = instr.i_fmt.rd[3:0];
                exec_next.alu_result = op_a + imm_i;  // ADDI result or load address
                exec_next.illegal    = instr.i_fmt.rd[4] | instr.i_fmt.rs1[4];
                if (instr.i_fmt.opcode == rv_core_pkg::op_load) begin
                    exec_next.mem_read = 1'b1;
                    if (instr.i_fmt.funct3 != rv_core_pkg::f3_word) exec_next.illegal = 1'b1;
                end else if (instr.i_fmt.funct3 != rv_core_pkg::f3_add_sub) begin
                    exec_next.illegal = 1'b1;  // Only ADDI is supported
                end
            end
            rv_core_pkg::op_store: begin
                exec_next.mem_write  = 1'b1;
                exec_next.alu_result = op_a + imm_s;
                exec_next.byte_store = (instr.s_fmt.funct3 == rv_core_pkg::f3_byte);
                exec_next.illegal    = instr.s_fmt.rs1[4] | instr.s_fmt.rs2[4];
                if (instr.s_fmt.funct3 != rv_core_pkg::f3_word &&
                    instr.s_fmt.funct3 != rv_core_pkg::f3_byte) begin
                    exec_next.illegal = 1'b1;
                end
            end
            default: exec_next.illegal = 1'b1;
        endcase
        // Bubbles and illegal instructions touch nothing
        if (!fetch.valid || exec_next.illegal) begin
            exec_next.reg_we    = 1'b0;
            exec_next.mem_read  = 1'b0;
            exec_next.mem_write = 1'b0;
        end
        exec_next.illegal = exec_next.illegal & fetch.valid;
    end

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            exec <= '0;
        end else if (step_en) begin
            exec <= exec_next;
        end
    end

endmodule

// File: mem_writeback.sv
`timescale 1ns/1ps

module mem_writeback #(
    parameter int unsigned dmem_depth = 256
) (
    input  logic                          cpu_clk,
    input  logic                          rst_n,
    input  logic                          step_en,
    input  rv_core_pkg::ex_to_mem_t       exec,
    output logic                          wb_we,
    output rv_core_pkg::reg_addr_t        wb_rd,
    output logic [rv_core_pkg::xlen-1:0]  wb_data,
    output rv_core_pkg::retire_t          retire,
    input  logic [31:0]                   debug_addr,
    output logic [31:0]                   debug_dmem_rdata
);

    localparam int unsigned dmem_aw = $clog2(dmem_depth);

    logic [31:0]                   dmem [dmem_depth];
    logic [dmem_aw-1:0]            mem_idx;
    logic [3:0]                    byte_en;
    logic [31:0]                   store_word;
    logic [31:0]                   load_data;
    rv_core_pkg::retire_t          retire_next;

    assign mem_idx = exec.alu_result[dmem_aw+1:2];

    // SB repeats the low byte across the word and byte_en picks the lane
    assign byte_en    = exec.byte_store ? (4'b0001 << exec.alu_result[1:0]) : 4'b1111;
    assign store_word = exec.byte_store ? {4{exec.store_data[7:0]}} : exec.store_data;

    always_ff @(posedge cpu_clk) begin
        if (step_en && exec.valid && exec.mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    dmem[mem_idx][8*b +: 8] <= store_word[8*b +: 8];
                end
            end
        end
    end

    assign load_data        = dmem[mem_idx];  // Asynchronous read in the same cycle
    assign debug_dmem_rdata = dmem[debug_addr[dmem_aw+1:2]];

    // Writeback toward the register file and the forwarding mux
    assign wb_we   = exec.valid && exec.reg_we;
    assign wb_rd   = exec.rd;
    assign wb_data = exec.mem_read ? load_data : exec.alu_result;

    always_comb begin
        retire_next.valid   = exec.valid;
        retire_next.pc      = exec.pc;
        retire_next.illegal = exec.illegal;
        retire_next.reg_we  = wb_we;
        retire_next.rd      = exec.rd;
        retire_next.wdata   = wb_we ? wb_data : '0;  // Zero when nothing is written
    end

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            retire <= '0;
        end else if (step_en) begin
            retire <= retire_next;
        end
    end

endmodule

// File: rv32e_system.sv
`timescale 1ns/1ps

module rv32e_system #(
    parameter int unsigned imem_depth = 256,
    parameter int unsigned dmem_depth = 256
) (
    input  logic                     cpu_clk,
    input  logic                     rst_n,
    input  logic                     step_en,        // Freezes the whole core when low
    input  logic                     debug_imem_we,
    input  logic [31:0]              debug_addr,
    input  logic [31:0]              debug_wdata,
    output logic [31:0]              debug_dmem_rdata,
    output rv_core_pkg::retire_t     retire
);

    rv_core_pkg::fetch_to_ex_t      fetch;
    rv_core_pkg::ex_to_mem_t        exec;
    logic                           wb_we;
    rv_core_pkg::reg_addr_t         wb_rd;
    logic [rv_core_pkg::xlen-1:0]   wb_data;

    instr_fetch #(
        .imem_depth (imem_depth)
    ) instr_fetch_i (
        .cpu_clk       (cpu_clk),
        .rst_n         (rst_n),
        .step_en       (step_en),
        .debug_imem_we (debug_imem_we),
        .debug_addr    (debug_addr),
        .debug_wdata   (debug_wdata),
        .fetch         (fetch)
    );

    // Register file lives inside this stage
    decode_execute decode_execute_i (
        .cpu_clk (cpu_clk),
        .rst_n   (rst_n),
        .step_en (step_en),
        .fetch   (fetch),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .exec    (exec)
    );

    mem_writeback #(
        .dmem_depth (dmem_depth)
    ) mem_writeback_i (
        .cpu_clk          (cpu_clk),
        .rst_n            (rst_n),
        .step_en          (step_en),
        .exec             (exec),
        .wb_we            (wb_we),
        .wb_rd            (wb_rd),
        .wb_data          (wb_data),
        .retire           (retire),
        .debug_addr       (debug_addr),
        .debug_dmem_rdata (debug_dmem_rdata)
    );

endmodule

// File: rv32e_system_properties.sv
`timescale 1ns/1ps

module rv32e_system_properties (
    input logic                  cpu_clk,
    input logic                  rst_n,
    input logic                  step_en,
    input rv_core_pkg::retire_t  retire
);

    int failures = 0;

    retire_idle_in_reset: assert property (@(posedge cpu_clk) !rst_n |-> !retire.valid)
        else begin
            failures++;
            $error("retire valid while reset is asserted");
        end

    // A frozen core holds its retire register
    retire_held_when_frozen: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        !step_en |=> $stable(retire))
        else begin
            failures++;
            $error("retire changed while step_en was low");
        end

    retire_pc_in_order: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        (step_en && retire.valid) |=> (!retire.valid || retire.pc == $past(retire.pc) + 32'd4))
        else begin
            failures++;
            $error("retire pc did not advance by 4");
        end

endmodule

bind rv32e_system rv32e_system_properties rv32e_system_properties_i (
    .cpu_clk (cpu_clk),
    .rst_n   (rst_n),
    .step_en (step_en),
    .retire  (retire)
);

// File: rv32e_system_tb.sv
`timescale 1ns/1ps

module rv32e_system_tb;

    localparam int unsigned imem_depth = 256;
    localparam int unsigned dmem_depth = 256;
    localparam int unsigned n_random   = 40;

    logic                  cpu_clk;
    logic                  rst_n;
    logic                  step_en;
    logic                  debug_imem_we;
    logic [31:0]           debug_addr;
    logic [31:0]           debug_wdata;
    logic [31:0]           debug_dmem_rdata;
    rv_core_pkg::retire_t  retire;

    logic [31:0]           prog [$];
    string                 prog_name [$];
    logic [31:0]           ref_regs [16];
    logic [31:0]           ref_mem [dmem_depth];
    rv_core_pkg::retire_t  exp_ret;
    int                    seed = 32'hc166;
    int                    retire_idx = 0;
    int                    checks = 0;
    int                    errors = 0;
    int                    prop_failures = 0;
    int                    cycles = 0;
    int                    limit;
    bit                    done = 1'b0;

    rv32e_system #(
        .imem_depth (imem_depth),
        .dmem_depth (dmem_depth)
    ) rv32e_system_i (
        .cpu_clk          (cpu_clk),
        .rst_n            (rst_n),
        .step_en          (step_en),
        .debug_imem_we    (debug_imem_we),
        .debug_addr       (debug_addr),
        .debug_wdata      (debug_wdata),
        .debug_dmem_rdata (debug_dmem_rdata),
        .retire           (retire)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #2 cpu_clk = ~cpu_clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    // ISA model that updates the testbench copy of registers and data memory
    function automatic rv_core_pkg::retire_t exec_ref(input logic [31:0] pc,
                                                      input logic [31:0] ins);
        rv_core_pkg::retire_t r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        bit          legal;
        bit          writes;
        rd     = ins[11:7];
        rs1    = ins[19:15];
        rs2    = ins[24:20];
        a      = ref_regs[rs1[3:0]];
        b      = ref_regs[rs2[3:0]];
        legal  = 1'b0;
        writes = 1'b0;
        res    = '0;
        addr   = '0;
        case (ins[6:0])
            7'h33: if (!(rd[4] || rs1[4] || rs2[4])) begin
                legal  = 1'b1;
                writes = 1'b1;
                case ({ins[31:25], ins[14:12]})  // funct7 and funct3
                    {7'h00, 3'd0}: res = a + b;
                    {7'h20, 3'd0}: res = a - b;
                    {7'h00, 3'd4}: res = a ^ b;
                    {7'h00, 3'd6}: res = a | b;
                    {7'h00, 3'd7}: res = a & b;
                    default:       legal = 1'b0;
                endcase
            end
            7'h13: if (ins[14:12] == 3'd0 && !rd[4] && !rs1[4]) begin
                legal  = 1'b1;
                writes = 1'b1;
                res    = a + {{20{ins[31]}}, ins[31:20]};
            end
            7'h03: if (ins[14:12] == 3'd2 && !rd[4] && !rs1[4]) begin
                legal  = 1'b1;
                writes = 1'b1;
                addr   = a + {{20{ins[31]}}, ins[31:20]};
                res    = ref_mem[addr[9:2]];  // 256 words of data memory
            end
            7'h23: if (!rs1[4] && !rs2[4]) begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (ins[14:12] == 3'd2) begin
                    legal = 1'b1;
                    ref_mem[addr[9:2]] = b;
                end else if (ins[14:12] == 3'd0) begin
                    legal = 1'b1;
                    ref_mem[addr[9:2]][8*addr[1:0] +: 8] = b[7:0];
                end
            end
            default: ;
        endcase
        r         = '0;
        r.valid   = 1'b1;
        r.pc      = pc;
        r.illegal = !legal;
        if (legal && writes) begin
            r.reg_we = 1'b1;
            r.rd     = rd[3:0];
            r.wdata  = res;
            if (rd[3:0] != 4'd0) ref_regs[rd[3:0]] = res;
        end
        return r;
    endfunction

    task automatic add_instr(input string name, input logic [31:0] ins);
        prog.push_back(ins);
        prog_name.push_back(name);
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        // Data region words 0..7 get known values before any load
        for (int w = 0; w < 8; w++) begin
            r = $random(seed);
            add_instr("dmem_init", enc_i(r[11:0], 5'd0, 3'd0, 5'(w + 1), 7'h13));
            add_instr("dmem_init", enc_s(12'(4 * w), 5'(w + 1), 5'd0, 3'd2));
        end
        add_instr("alu_chain", enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
        add_instr("alu_chain", enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        add_instr("alu_chain", enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
        add_instr("alu_chain", enc_r(7'h00, 5'd2, 5'd3, 3'd4, 5'd4));
        add_instr("alu_chain", enc_r(7'h00, 5'd1, 5'd4, 3'd6, 5'd5));
        add_instr("alu_chain", enc_r(7'h00, 5'd5, 5'd3, 3'd7, 5'd6));
        add_instr("x0_write", enc_i(12'd9, 5'd4, 3'd0, 5'd0, 7'h13));
        add_instr("x0_write", enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd7));
        add_instr("x0_write", enc_r(7'h00, 5'd4, 5'd0, 3'd0, 5'd8));
        // Byte stores into word 0 and then load-use straight away
        add_instr("load_store", enc_s(12'd1, 5'd4, 5'd0, 3'd0));
        add_instr("load_store", enc_s(12'd3, 5'd2, 5'd0, 3'd0));
        add_instr("load_store", enc_i(12'd0, 5'd0, 3'd2, 5'd9, 7'h03));
        add_instr("load_store", enc_r(7'h00, 5'd9, 5'd9, 3'd0, 5'd10));
        add_instr("load_store", enc_s(12'd4, 5'd10, 5'd0, 3'd2));
        add_instr("load_store", enc_i(12'd4, 5'd0, 3'd2, 5'd11, 7'h03));
        add_instr("illegal", 32'h0000_067f);                          // Unknown opcode
        add_instr("illegal", enc_r(7'h00, 5'd1, 5'd17, 3'd0, 5'd12));
        add_instr("illegal", enc_s(12'd8, 5'd20, 5'd0, 3'd2));        // Store from x20
        add_instr("illegal", enc_r(7'h00, 5'd12, 5'd12, 3'd0, 5'd13));
        for (int i = 0; i < n_random; i++) begin
            r   = $random(seed);
            rd  = 5'(1 + r[7:4] % 15);
            rs1 = {1'b0, r[11:8]};
            rs2 = {1'b0, r[15:12]};
            imm = r[27:16];
            case (r[2:0])
                3'd0: add_instr("random", enc_r(7'h00, rs2, rs1, 3'd0, rd));
                3'd1: add_instr("random", enc_r(7'h20, rs2, rs1, 3'd0, rd));
                3'd2: add_instr("random", enc_r(7'h00, rs2, rs1, 3'd7, rd));
                3'd3: add_instr("random", enc_r(7'h00, rs2, rs1, 3'd6, rd));
                3'd4: add_instr("random", enc_r(7'h00, rs2, rs1, 3'd4, rd));
                3'd5: add_instr("random", enc_i(imm, rs1, 3'd0, rd, 7'h13));
                3'd6: add_instr("random", enc_i({7'b0, r[20:18], 2'b00}, 5'd0, 3'd2, rd, 7'h03));
                default: begin
                    if (r[3]) add_instr("random", enc_s({7'b0, r[20:16]}, rs2, 5'd0, 3'd0));
                    else add_instr("random", enc_s({7'b0, r[20:18], 2'b00}, rs2, 5'd0, 3'd2));
                end
            endcase
        end
        add_instr("padding", 32'h0000_0013);
        add_instr("padding", 32'h0000_0013);
    endtask

    // Whole instruction memory is written with NOP past the program
    task automatic load_program();
        for (int i = 0; i < imem_depth; i++) begin
            @(posedge cpu_clk);
            debug_imem_we <= 1'b1;
            debug_addr    <= 32'(4 * i);
            debug_wdata   <= (i < prog.size()) ? prog[i] : 32'h0000_0013;
        end
        @(posedge cpu_clk);
        debug_imem_we <= 1'b0;
    endtask

    task automatic compare_field(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic check_dmem();
        for (int w = 0; w < 8; w++) begin
            @(posedge cpu_clk);
            debug_addr <= 32'(4 * w);
            @(negedge cpu_clk);
            compare_field("dmem_final", $sformatf("word %0d", w), ref_mem[w], debug_dmem_rdata);
        end
    endtask

    // A retire is consumed on the next enabled edge so it is checked once just before
    always @(negedge cpu_clk) begin
        string test;
        if (rst_n && step_en && retire.valid && !done) begin
            test    = $sformatf("%s[%0d]", prog_name[retire_idx], retire_idx);
            exp_ret = exec_ref(32'(4 * retire_idx), prog[retire_idx]);
            compare_field(test, "pc", exp_ret.pc, retire.pc);
            compare_field(test, "illegal", 32'(exp_ret.illegal), 32'(retire.illegal));
            compare_field(test, "reg_we", 32'(exp_ret.reg_we), 32'(retire.reg_we));
            if (exp_ret.reg_we) compare_field(test, "rd", 32'(exp_ret.rd), 32'(retire.rd));
            compare_field(test, "wdata", exp_ret.wdata, retire.wdata);
            retire_idx++;
            if (retire_idx == prog.size()) done = 1'b1;
        end
    end

    initial begin
        rst_n         = 1'b0;
        step_en       = 1'b0;
        debug_imem_we = 1'b0;
        debug_addr    = '0;
        debug_wdata   = '0;
        for (int i = 0; i < 16; i++) ref_regs[i] = '0;
        build_program();
        limit = 4 * prog.size() + 50;
        repeat (2) @(posedge cpu_clk);
        rst_n <= 1'b1;
        load_program();
        while (!done && cycles < limit) begin
            @(posedge cpu_clk);
            step_en <= (($random(seed) & 3) != 0);  // Frozen on about one edge in four
            cycles++;
        end
        @(posedge cpu_clk);
        step_en <= 1'b0;
        if (!done) begin
            errors++;
            $display("Timeout: only %0d of %0d instructions retired in %0d cycles",
                     retire_idx, prog.size(), cycles);
        end
        check_dmem();
        prop_failures = rv32e_system_i.rv32e_system_properties_i.failures;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, prop_failures);
        if (errors == 0 && prop_failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: rv32e_system.f
rv_core_pkg.sv
instr_fetch.sv
register_file.sv
decode_execute.sv
mem_writeback.sv
rv32e_system.sv
rv32e_system_properties.sv
rv32e_system_tb.sv

// File: Bender.yml
package:
  name: rv32e_system

sources:
  - rv_core_pkg.sv
  - instr_fetch.sv
  - register_file.sv
  - decode_execute.sv
  - mem_writeback.sv
  - rv32e_system.sv
  - target: test
    files:
      - rv32e_system_properties.sv
      - rv32e_system_tb.sv
